// ==== compile.f ====
+incdir+design
design/soc_bus_pkg.sv
design/addr_decoder.sv
design/simple_pic.sv
design/cpu_data_return.sv
design/soc_bus_top.sv
bench/soc_bus_asserts.sv
bench/soc_bus_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the bus fabric testbench with Verilator, run it and look for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f compile.f \
  --top-module soc_bus_tb

# An assertion stop ends the run with a nonzero status, the search below decides
sim_out=$(./obj_dir/Vsoc_bus_tb 2>&1) || true
echo "$sim_out"

if grep -qx "Test completed successfully" <<< "$sim_out"; then
  exit 0
else
  echo "Simulation did not report success"
  exit 1
fi

// ==== bench/soc_bus_tb.sv ====
// Testbench for the CPU bus fabric
// Six slave models, directed decode, write, interrupt and NMI tests,
// a watchdog and an error summary

`timescale 1ns/1ps
`include "soc_bus_macros.svh"

module soc_bus_tb import soc_bus_pkg::*; ();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int ACK_WAIT     = 16;  // Clocks a cycle may wait for ack
  localparam int ACCESSES     = 24;  // Bus cycles over all tests
  localparam int ACCESS_LEN   = 3;
  localparam int EXTRA_CYCLES = 20;  // Interrupt pulses and checks
  localparam int WATCHDOG_NS  =
    2 * CLK_PERIOD * (RESET_CYCLES + ACCESSES * ACCESS_LEN + EXTRA_CYCLES);

  logic                           clk = 1'b0;
  logic                           rst_lck;
  bus_req_t                       cpu_req;
  logic                           cpu_cyc;
  logic                           cpu_stb;
  logic                           inta;
  logic                           nmia;
  logic [`SOC_NUM_IRQ-1:0]        intv;
  bus_rsp_t [`SOC_NUM_SLAVES-1:0] slv_rsp;
  logic [`SOC_DAT_W-1:0]          cpu_dat;
  logic                           cpu_ack;
  logic                           intr;
  bus_req_t                       slv_req;
  slave_sel_t                     slv_cyc;
  logic                           slv_stb;

  bus_req_t last_req [`SOC_NUM_SLAVES];  // Last request each slave took
  int       errors = 0;
  int       checks = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  soc_bus_top dut_i (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .cpu_req_i (cpu_req),
    .cpu_cyc_i (cpu_cyc),
    .cpu_stb_i (cpu_stb),
    .inta_i    (inta),
    .nmia_i    (nmia),
    .intv_i    (intv),
    .slv_rsp_i (slv_rsp),
    .cpu_dat_o (cpu_dat),
    .cpu_ack_o (cpu_ack),
    .intr_o    (intr),
    .slv_req_o (slv_req),
    .slv_cyc_o (slv_cyc),
    .slv_stb_o (slv_stb)
  );

  // Slave k answers at once with 0xA000 + k
  always_comb begin
    for (int k = 0; k < `SOC_NUM_SLAVES; k++) begin
      slv_rsp[k].dat = 16'hA000 + 16'(k);
      slv_rsp[k].ack = slv_cyc[k] && slv_stb;
    end
  end

  always @(posedge clk) begin
    for (int k = 0; k < `SOC_NUM_SLAVES; k++) begin
      if (slv_cyc[k] && slv_stb) begin
        last_req[k] <= slv_req;
      end
    end
  end

  task automatic compare_values(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // Expected slot by address range or -1 for the default slave
  function automatic int expected_slot(input logic io, input logic [19:0] a);
    if (!io) begin
      if (a >= 20'hFFF00) return `SLV_ROM;
      if (a >= 20'hA0000 && a <= 20'hBFFFF) return `SLV_VGA;
      return `SLV_RAM;
    end
    if (a >= 20'h003C0 && a <= 20'h003DF) return `SLV_VGA;
    if (a >= 20'h003F8 && a <= 20'h003FF) return `SLV_UART;
    if (a == 20'h00060 || a == 20'h00064) return `SLV_KEYB;
    if (a >= 20'h00040 && a <= 20'h00043) return `SLV_TIMER;
    return -1;
  endfunction

  function automatic bus_req_t make_req(input logic io, input logic [19:0] byte_adr,
                                        input logic [15:0] dat, input logic [1:0] sel,
                                        input logic we);
    bus_req_t r;
    r.adr = byte_adr[19:1];  // Word address
    r.io  = io;
    r.dat = dat;
    r.sel = sel;
    r.we  = we;
    return r;
  endfunction

  // One CPU cycle that returns what the CPU and slave lines showed at ack
  task automatic bus_cycle(input bus_req_t req, input logic inta_lvl, input logic nmia_lvl,
                           output logic [15:0] rdat, output slave_sel_t cyc_seen,
                           output logic acked);
    int waited;
    @(posedge clk);
    #1;
    cpu_req  = req;
    cpu_cyc  = 1'b1;
    cpu_stb  = 1'b1;
    inta     = inta_lvl;
    nmia     = nmia_lvl;
    acked    = 1'b0;
    rdat     = '0;
    cyc_seen = '0;
    waited   = 0;
    while (!acked && waited < ACK_WAIT) begin
      @(negedge clk);  // Outputs settled well clear of the edge
      if (cpu_ack === 1'b1) begin
        acked    = 1'b1;
        rdat     = cpu_dat;
        cyc_seen = slv_cyc;
      end
      waited++;
    end
    @(posedge clk);  // Ack edge
    #1;
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;
    inta    = 1'b0;
    nmia    = 1'b0;
    cpu_req = '0;
  endtask

  task automatic access_and_check(input logic io, input logic [19:0] a, input logic we);
    bus_req_t    req;
    logic [15:0] rdat;
    slave_sel_t  cyc_seen;
    logic        acked;
    int          slot;
    logic [2:0]  idx;
    string       tag;
    if (we) begin
      req = make_req(io, a, 16'($urandom), 2'($urandom), 1'b1);
    end else begin
      req = make_req(io, a, 16'h0000, 2'b11, 1'b0);
    end
    slot = expected_slot(io, a);
    tag  = $sformatf("%s %s 0x%05h", we ? "write" : "read", io ? "io" : "mem", a);
    bus_cycle(req, 1'b0, 1'b0, rdat, cyc_seen, acked);
    compare_values({tag, " ack"}, 64'(acked), 64'd1);
    if (slot < 0) begin
      compare_values({tag, " slot lines"}, 64'(cyc_seen), 64'd0);
      compare_values({tag, " default data"}, 64'(rdat), 64'd0);
    end else begin
      idx = 3'(slot);
      compare_values({tag, " slot lines"}, 64'(cyc_seen), 64'(slave_sel_t'(1) << slot));
      if (!we) begin
        compare_values({tag, " data"}, 64'(rdat), 64'(16'hA000 + 16'(slot)));
      end
      compare_values({tag, " request at slave"}, 64'(last_req[idx]), 64'(req));
    end
  endtask

  task automatic pulse_irq(input logic [2:0] line);
    @(posedge clk);
    #1;
    intv[line] = 1'b1;
    @(posedge clk);
    #1;
    intv[line] = 1'b0;
  endtask

  function automatic logic [15:0] irq_vector(input logic [2:0] line);
    return `SOC_IRQ_VECTOR_BASE + 16'(line);
  endfunction

  task automatic check_reset_state();
    @(negedge clk);
    compare_values("intr_o after reset", 64'(intr), 64'd0);
    compare_values("slv_cyc_o after reset", 64'(slv_cyc), 64'd0);
    compare_values("slv_stb_o with no strobe", 64'(slv_stb), 64'd0);
  endtask

  task automatic decode_map_regions();
    access_and_check(1'b0, 20'hFFF00, 1'b0);  // ROM
    access_and_check(1'b0, 20'hFFFFF, 1'b0);
    access_and_check(1'b0, 20'hA0000, 1'b0);  // VGA memory
    access_and_check(1'b0, 20'hBFFFF, 1'b0);
    access_and_check(1'b1, 20'h003C0, 1'b0);  // VGA I/O
    access_and_check(1'b1, 20'h003DF, 1'b0);
    access_and_check(1'b1, 20'h003D4, 1'b0);
    access_and_check(1'b1, 20'h003F8, 1'b0);  // UART
    access_and_check(1'b1, 20'h003FF, 1'b0);
    access_and_check(1'b1, 20'h00060, 1'b0);  // Keyboard
    access_and_check(1'b1, 20'h00064, 1'b0);
    access_and_check(1'b1, 20'h00040, 1'b0);  // Timer
    access_and_check(1'b1, 20'h00043, 1'b0);
    access_and_check(1'b0, 20'h00000, 1'b0);  // Base RAM
    access_and_check(1'b0, 20'hFFEFF, 1'b0);
    access_and_check(1'b0, 20'h9FFFE, 1'b0);
    access_and_check(1'b0, 20'h12344, 1'b0);
  endtask

  task automatic default_slave_read();
    access_and_check(1'b1, 20'h00500, 1'b0);  // Nothing mapped here
  endtask

  task automatic write_fanout();
    access_and_check(1'b1, 20'h003F8, 1'b1);
    access_and_check(1'b0, 20'h12344, 1'b1);
  endtask

  task automatic interrupt_acks();
    bus_req_t    req;
    logic [15:0] rdat;
    slave_sel_t  cyc_seen;
    logic        acked;
    pulse_irq(3'd4);
    pulse_irq(3'd1);
    @(negedge clk);
    compare_values("intr_o after pulses", 64'(intr), 64'd1);
    req = make_req(1'b0, 20'h00000, 16'h0000, 2'b11, 1'b0);
    // Lowest line first
    bus_cycle(req, 1'b1, 1'b0, rdat, cyc_seen, acked);
    compare_values("first inta ack", 64'(acked), 64'd1);
    compare_values("first inta vector", 64'(rdat), 64'(irq_vector(3'd1)));
    compare_values("first inta slot lines", 64'(cyc_seen), 64'd0);
    bus_cycle(req, 1'b1, 1'b0, rdat, cyc_seen, acked);
    compare_values("second inta ack", 64'(acked), 64'd1);
    compare_values("second inta vector", 64'(rdat), 64'(irq_vector(3'd4)));
    @(negedge clk);
    compare_values("intr_o after both inta", 64'(intr), 64'd0);
  endtask

  task automatic nmi_over_inta();
    bus_req_t    req;
    logic [15:0] rdat;
    slave_sel_t  cyc_seen;
    logic        acked;
    req = make_req(1'b0, 20'hFFF00, 16'h0000, 2'b11, 1'b0);
    bus_cycle(req, 1'b1, 1'b1, rdat, cyc_seen, acked);
    compare_values("nmia ack", 64'(acked), 64'd1);
    compare_values("nmia vector", 64'(rdat), 64'(`SOC_NMI_VECTOR));
    compare_values("nmia slot lines", 64'(cyc_seen), 64'd0);
  endtask

  initial begin
    void'($urandom(46505));
    rst_lck = 1'b0;
    cpu_req = '0;
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;
    inta    = 1'b0;
    nmia    = 1'b0;
    intv    = '0;
    // Request lines toggle inside reset and must not latch
    repeat (4) @(posedge clk);
    #1;
    intv = 8'hA5;
    repeat (4) @(posedge clk);
    #1;
    intv = '0;
    repeat (RESET_CYCLES - 8) @(posedge clk);
    #1;
    rst_lck = 1'b1;

    check_reset_state();
    decode_map_regions();
    default_slave_read();
    write_fanout();
    interrupt_acks();
    nmi_over_inta();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== bench/soc_bus_asserts.sv ====
// Bus fabric protocol assertions
// Bound to the top level, watches the slave cycle lines and the interrupt output

`timescale 1ns/1ps

module soc_bus_asserts import soc_bus_pkg::*; (
  input logic       clk,
  input logic       rst_lck,
  input logic       cpu_cyc_i,
  input slave_sel_t slv_cyc_o,
  input logic       intr_o
);

  // Never two slaves in one cycle
  cyc_onehot_a: assert property (@(posedge clk) $onehot0(slv_cyc_o))
    else $error("More than one slave cycle line is high: %b", slv_cyc_o);

  cyc_idle_a: assert property (@(posedge clk) !cpu_cyc_i |-> slv_cyc_o == '0)
    else $error("A slave cycle line is high while the CPU has no cycle");

  // Pending bits are cleared one edge into reset
  intr_reset_a: assert property (@(posedge clk)
    (!rst_lck && !$past(rst_lck)) |-> !intr_o)
    else $error("intr_o is high during reset");

endmodule

bind soc_bus_top soc_bus_asserts u_asserts (
  .clk       (clk),
  .rst_lck   (rst_lck),
  .cpu_cyc_i (cpu_cyc_i),
  .slv_cyc_o (slv_cyc_o),
  .intr_o    (intr_o)
);

// ==== design/soc_bus_top.sv ====
// CPU bus fabric top level
// Address decoder, interrupt controller and data return stage;
// the slaves sit outside on the slv_* ports

`timescale 1ns/1ps
`include "soc_bus_macros.svh"

module soc_bus_top import soc_bus_pkg::*; (
  input  logic                           clk,
  input  logic                           rst_lck,
  input  bus_req_t                       cpu_req_i,
  input  logic                           cpu_cyc_i,
  input  logic                           cpu_stb_i,
  input  logic                           inta_i,
  input  logic                           nmia_i,
  input  logic [`SOC_NUM_IRQ-1:0]        intv_i,
  input  bus_rsp_t [`SOC_NUM_SLAVES-1:0] slv_rsp_i,
  output logic [`SOC_DAT_W-1:0]          cpu_dat_o,
  output logic                           cpu_ack_o,
  output logic                           intr_o,
  output bus_req_t                       slv_req_o,
  output slave_sel_t                     slv_cyc_o,
  output logic                           slv_stb_o
);

  slave_sel_t            sel;      // Decoded slot, not gated by cyc
  logic                  def_sel;
  logic [`SOC_IID_W-1:0] iid;

  addr_decoder u_decoder (
    .cpu_req_i (cpu_req_i),
    .cpu_cyc_i (cpu_cyc_i),
    .cpu_stb_i (cpu_stb_i),
    .inta_i    (inta_i),
    .nmia_i    (nmia_i),
    .slv_req_o (slv_req_o),
    .slv_cyc_o (slv_cyc_o),
    .slv_stb_o (slv_stb_o),
    .sel_o     (sel),
    .def_sel_o (def_sel)
  );

  simple_pic u_pic (
    .clk     (clk),
    .rst_lck (rst_lck),
    .intv_i  (intv_i),
    .inta_i  (inta_i),
    .intr_o  (intr_o),
    .iid_o   (iid)
  );

  cpu_data_return u_return (
    .cpu_cyc_i (cpu_cyc_i),
    .cpu_stb_i (cpu_stb_i),
    .sel_i     (sel),
    .def_sel_i (def_sel),
    .slv_rsp_i (slv_rsp_i),
    .iid_i     (iid),
    .inta_i    (inta_i),
    .nmia_i    (nmia_i),
    .cpu_dat_o (cpu_dat_o),
    .cpu_ack_o (cpu_ack_o)
  );

endmodule

// ==== design/cpu_data_return.sv ====
// CPU data return stage
// Picks the selected slave's answer, or the default slave's zero,
// and lets NMI and interrupt acknowledge reads return their vectors

`timescale 1ns/1ps
`include "soc_bus_macros.svh"

module cpu_data_return import soc_bus_pkg::*; (
  input  logic                              cpu_cyc_i,
  input  logic                              cpu_stb_i,
  input  slave_sel_t                        sel_i,
  input  logic                              def_sel_i,
  input  bus_rsp_t [`SOC_NUM_SLAVES-1:0]    slv_rsp_i,
  input  logic [`SOC_IID_W-1:0]             iid_i,
  input  logic                              inta_i,
  input  logic                              nmia_i,
  output logic [`SOC_DAT_W-1:0]             cpu_dat_o,
  output logic                              cpu_ack_o
);

  logic [`SOC_DAT_W-1:0] slv_dat;
  logic                  slv_ack;
  logic [`SOC_DAT_W-1:0] irq_vector;
  logic                  bus_act;
  bus_rsp_t              def_rsp;

  assign bus_act = cpu_cyc_i && cpu_stb_i;

  // AND-OR mux, select is one-hot
  always_comb begin
    slv_dat = '0;
    slv_ack = 1'b0;
    for (int k = 0; k < `SOC_NUM_SLAVES; k++) begin
      if (sel_i[k]) begin
        slv_dat = slv_dat | slv_rsp_i[k].dat;
        slv_ack = slv_ack | slv_rsp_i[k].ack;
      end
    end
  end

  // Internal default slave answers at once with zero
  assign def_rsp.dat = '0;
  assign def_rsp.ack = def_sel_i && bus_act;

  assign irq_vector = `SOC_IRQ_VECTOR_BASE +
                      {{(`SOC_DAT_W - `SOC_IID_W){1'b0}}, iid_i};

  always_comb begin
    if (nmia_i) begin
      cpu_dat_o = `SOC_NMI_VECTOR;
      cpu_ack_o = bus_act;
    end else if (inta_i) begin
      cpu_dat_o = irq_vector;
      cpu_ack_o = bus_act;
    end else if (|sel_i) begin
      cpu_dat_o = slv_dat;
      cpu_ack_o = slv_ack && cpu_cyc_i;  // Slave holds ack low to stall
    end else begin
      cpu_dat_o = def_rsp.dat;
      cpu_ack_o = def_rsp.ack;
    end
  end

endmodule

// ==== design/simple_pic.sv ====
// Simple interrupt controller
// Latches rising edges on the request lines and presents the
// lowest pending line as the interrupt id

`timescale 1ns/1ps
`include "soc_bus_macros.svh"

module simple_pic (
  input  logic                  clk,
  input  logic                  rst_lck,
  input  logic [`SOC_NUM_IRQ-1:0] intv_i,
  input  logic                  inta_i,
  output logic                  intr_o,
  output logic [`SOC_IID_W-1:0] iid_o
);

  logic [`SOC_NUM_IRQ-1:0] intv_q;    // Request levels one clock ago
  logic [`SOC_NUM_IRQ-1:0] pending;
  logic [`SOC_NUM_IRQ-1:0] rise;
  logic [`SOC_NUM_IRQ-1:0] ack_clr;   // Bit named by iid during inta
  logic [`SOC_IID_W-1:0]   iid;

  assign rise = intv_i & ~intv_q;

  // Lowest pending index, scanned from the top down
  always_comb begin
    iid = '0;
    for (int i = `SOC_NUM_IRQ - 1; i >= 0; i--) begin
      if (pending[i]) begin
        iid = i[`SOC_IID_W-1:0];
      end
    end
  end

  always_comb begin
    ack_clr = '0;
    if (inta_i) begin
      ack_clr[iid] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      intv_q  <= '0;
      pending <= '0;
    end else begin
      intv_q  <= intv_i;
      pending <= (pending & ~ack_clr) | rise;  // A fresh edge beats the clear
    end
  end

  assign intr_o = |pending;
  assign iid_o  = iid;

endmodule

// ==== design/addr_decoder.sv ====
// CPU address decoder
// Matches each cycle against the address and mask table and
// drives the cycle line of one slave, or flags the default slave

`timescale 1ns/1ps
`include "soc_bus_macros.svh"

module addr_decoder import soc_bus_pkg::*; (
  input  bus_req_t   cpu_req_i,
  input  logic       cpu_cyc_i,
  input  logic       cpu_stb_i,
  input  logic       inta_i,
  input  logic       nmia_i,
  output bus_req_t   slv_req_o,
  output slave_sel_t slv_cyc_o,
  output logic       slv_stb_o,
  output slave_sel_t sel_o,
  output logic       def_sel_o
);

  logic [`SOC_ADR_W:0] dec_adr;    // {io, adr}
  slave_sel_t          hit;        // Every slot whose entry matches
  slave_sel_t          first_hit;  // Lowest index only
  slave_sel_t          sel;
  logic                dec_en;

  // One table entry
  function automatic logic map_hit(
    input logic [`SOC_ADR_W:0] adr,
    input logic [`SOC_ADR_W:0] mask,
    input logic [`SOC_ADR_W:0] base
  );
    return (adr & mask) == base;
  endfunction

  assign dec_adr = {cpu_req_i.io, cpu_req_i.adr};

  // Acknowledge reads belong to the CPU, no slave takes part
  assign dec_en = !(inta_i || nmia_i);

  always_comb begin
    hit = '0;
    hit[`SLV_ROM]   = map_hit(dec_adr, `ROM_MASK, `ROM_ADDR);
    hit[`SLV_VGA]   = map_hit(dec_adr, `VGA_MEM_MASK, `VGA_MEM_ADDR) ||
                      map_hit(dec_adr, `VGA_IO_MASK, `VGA_IO_ADDR);  // Two windows
    hit[`SLV_UART]  = map_hit(dec_adr, `UART_MASK, `UART_ADDR);
    hit[`SLV_KEYB]  = map_hit(dec_adr, `KEYB_MASK, `KEYB_ADDR);
    hit[`SLV_TIMER] = map_hit(dec_adr, `TIMER_MASK, `TIMER_ADDR);
    hit[`SLV_RAM]   = map_hit(dec_adr, `RAM_MASK, `RAM_ADDR);  // Catches all memory
  end

  // Isolate lowest set bit, so ROM wins over base RAM
  assign first_hit = hit & (~hit + slave_sel_t'(1));

  assign sel       = dec_en ? first_hit : '0;
  assign def_sel_o = dec_en && (hit == '0);  // Unmapped I/O only
  assign sel_o     = sel;

  // Fan out, only the selected slave sees a cycle
  assign slv_cyc_o = cpu_cyc_i ? sel : '0;
  assign slv_stb_o = cpu_stb_i;
  assign slv_req_o = cpu_req_i;

endmodule

// ==== design/soc_bus_pkg.sv ====
// Shared types of the CPU bus fabric
// Request and response bundles plus the one-hot slot select

`include "soc_bus_macros.svh"

package soc_bus_pkg;

  // CPU request as seen by every slave
  // io is the cycle tag: high for I/O space, low for memory
  typedef struct packed {
    logic [`SOC_ADR_W-1:0] adr;  // Word address
    logic                  io;
    logic [`SOC_DAT_W-1:0] dat;  // Write data
    logic [`SOC_SEL_W-1:0] sel;  // Byte selects
    logic                  we;
  } bus_req_t;

  // Slave answer back to the fabric
  typedef struct packed {
    logic [`SOC_DAT_W-1:0] dat;  // Read data
    logic                  ack;
  } bus_rsp_t;

  // One bit per external slot, indexed by the SLV_* macros
  typedef logic [`SOC_NUM_SLAVES-1:0] slave_sel_t;

endpackage

// ==== design/soc_bus_macros.svh ====
// Bus fabric constants for the CPU side of the SoC
// Widths, slave slot indices, the address map and the CPU vectors
// Map entries are 20 bits: I/O flag on top, word address below

`ifndef SOC_BUS_MACROS_SVH
`define SOC_BUS_MACROS_SVH

// Bus widths
`define SOC_ADR_W       19  // Word address, byte address bits 19:1
`define SOC_DAT_W       16
`define SOC_SEL_W       2
`define SOC_NUM_SLAVES  6

// Slot indices, lower index wins the decode
`define SLV_ROM    0
`define SLV_VGA    1
`define SLV_UART   2
`define SLV_KEYB   3
`define SLV_TIMER  4
`define SLV_RAM    5

// Address map as {io, adr[19:1]}
`define ROM_ADDR      20'h7FF80  // mem 0xFFF00 - 0xFFFFF
`define ROM_MASK      20'hFFF80
`define VGA_MEM_ADDR  20'h50000  // mem 0xA0000 - 0xBFFFF
`define VGA_MEM_MASK  20'hF0000
`define VGA_IO_ADDR   20'h801E0  // io 0x3C0 - 0x3DF
`define VGA_IO_MASK   20'h87FF0
`define UART_ADDR     20'h801FC  // io 0x3F8 - 0x3FF
`define UART_MASK     20'h87FFC
`define KEYB_ADDR     20'h80030  // io 0x60 and 0x64
`define KEYB_MASK     20'h87FFD
`define TIMER_ADDR    20'h80020  // io 0x40 - 0x43
`define TIMER_MASK    20'h87FFE
`define RAM_ADDR      20'h00000  // Any memory address
`define RAM_MASK      20'h80000

// Interrupts
`define SOC_NUM_IRQ          8
`define SOC_IID_W            3
`define SOC_NMI_VECTOR       16'h0002
`define SOC_IRQ_VECTOR_BASE  16'd8   // Vector is base plus id

`endif
